//--- common/fetch_pkg.sv
package fetch_pkg;

    // basic widths fixed by the rv32 isa
    typedef logic [31:0] word_t;      // instruction or data word
    typedef logic [31:0] addr_t;      // byte address, pc
    typedef logic [7:0]  mem_idx_t;   // word index, pc[9:2]
    typedef logic [4:0]  reg_idx_t;   // rd field

    // pc after reset
    localparam addr_t reset_pc = 32'h8000_0000;

    // instruction memory size in words
    localparam int mem_depth = 256;

    // major opcode of jal
    localparam logic [6:0] opcode_jal = 7'b1101111;

    // fetch loop
    // req       -> one cycle with the sram read strobe
    // wait_data -> word comes back on rd_done
    // hold      -> word offered to decode until taken
    typedef enum logic [1:0] {
        req       = 2'd0,
        wait_data = 2'd1,
        hold      = 2'd2
    } fetch_state_t;

endpackage

//--- fetch/fetch_unit.sv
module fetch_unit (
    input  logic                     clk,
    input  logic                     rst,
    // handshake with decode
    input  logic                     inst_ready,
    input  logic                     jump_en,
    input  fetch_pkg::addr_t         jump_pc,
    // sram read return
    input  fetch_pkg::word_t         rd_data,
    input  logic                     rd_done,
    // sram read request
    output logic                     rd_en,
    output fetch_pkg::mem_idx_t      rd_idx,
    // toward decode
    output logic                     inst_valid,
    output fetch_pkg::addr_t         inst_pc,
    output fetch_pkg::word_t         inst_word
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t next_state;

    fetch_pkg::addr_t pc;          // pc of the word being fetched / held
    fetch_pkg::addr_t next_pc;     // step or redirect target
    fetch_pkg::word_t inst_q;      // captured instruction
    logic             xfer;        // decode takes the word this cycle

    // state decode
    assign rd_en      = (state == fetch_pkg::req);   // one read per instruction
    assign inst_valid = (state == fetch_pkg::hold);
    assign xfer       = inst_valid && inst_ready;

    // word index straight from pc
    assign rd_idx = pc[9:2];

    // jal redirect wins over sequential step
    assign next_pc = jump_en ? jump_pc : pc + 32'd4;

    // next state
    always_comb begin
        next_state = state;
        case (state)
            fetch_pkg::req: begin
                next_state = fetch_pkg::wait_data;   // read issued this cycle
            end
            fetch_pkg::wait_data: begin
                if (rd_done) begin
                    next_state = fetch_pkg::hold;
                end
            end
            fetch_pkg::hold: begin
                // stay until decode has room
                if (xfer) begin
                    next_state = fetch_pkg::req;
                end
            end
            default: begin
                next_state = fetch_pkg::req;
            end
        endcase
    end

    // state and pc
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch_pkg::req;
            pc    <= fetch_pkg::reset_pc;
        end else begin
            state <= next_state;
            if (xfer) begin
                pc <= next_pc;   // same edge as the transfer
            end
        end
    end

    // word taken when the read returns
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::wait_data && rd_done) begin
            inst_q <= rd_data;
        end
    end

    assign inst_pc   = pc;       // stable while in hold
    assign inst_word = inst_q;

endmodule

//--- fetch/inst_sram.sv
module inst_sram (
    input  logic                     clk,
    // read port, one cycle latency
    input  logic                     rd_en,
    input  fetch_pkg::mem_idx_t      rd_idx,
    output fetch_pkg::word_t         rd_data,
    output logic                     rd_done,
    // load port from outside
    input  logic                     wr_en,
    input  fetch_pkg::mem_idx_t      wr_idx,
    input  fetch_pkg::word_t         wr_data
);

    fetch_pkg::word_t mem [fetch_pkg::mem_depth];

    // load writes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read
    // same index written this cycle gives the old word back
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

    // done strobe trails the request by one cycle
    always_ff @(posedge clk) begin
        rd_done <= rd_en;
    end

endmodule

//--- src/decode_unit.sv
module decode_unit (
    input  logic                     clk,
    input  logic                     rst,
    // from fetch
    input  logic                     inst_valid,
    input  fetch_pkg::addr_t         inst_pc,
    input  fetch_pkg::word_t         inst_word,
    // back to fetch
    output logic                     inst_ready,
    output logic                     jump_en,
    output fetch_pkg::addr_t         jump_pc,
    // output entry toward the consumer
    output logic                     out_valid,
    input  logic                     out_ready,
    output fetch_pkg::addr_t         out_pc,
    output fetch_pkg::word_t         out_inst,
    output fetch_pkg::reg_idx_t      out_rd,
    output logic                     out_is_jal
);

    logic [6:0]          opcode;
    logic                is_jal;
    fetch_pkg::word_t    j_imm;     // sign-extended j immediate
    fetch_pkg::reg_idx_t rd;
    logic                xfer;

    // field split
    assign opcode = inst_word[6:0];
    assign rd     = inst_word[11:7];

    assign is_jal = (opcode == fetch_pkg::opcode_jal);

    // j-type immediate, imm[20|10:1|11|19:12], bit 0 always zero
    assign j_imm = {
        {12{inst_word[31]}},
        inst_word[19:12],
        inst_word[20],
        inst_word[30:21],
        1'b0
    };

    // redirect path, purely combinational
    assign jump_en = is_jal;
    assign jump_pc = inst_pc + j_imm;   // wraps naturally mod 2^32

    // room when empty or the entry leaves this cycle
    assign inst_ready = !out_valid || out_ready;
    assign xfer       = inst_valid && inst_ready;

    // entry valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (xfer) begin
            out_valid <= 1'b1;     // new item replaces or fills
        end else if (out_ready) begin
            out_valid <= 1'b0;     // taken, nothing new behind it
        end
    end

    // payload, held until the next transfer
    always_ff @(posedge clk) begin
        if (xfer) begin
            out_pc     <= inst_pc;
            out_inst   <= inst_word;
            out_rd     <= rd;
            out_is_jal <= is_jal;
        end
    end

endmodule

//--- src/fetch_top.sv
module fetch_top (
    input  logic                     clk,
    input  logic                     rst,
    // program load
    input  logic                     load_en,
    input  fetch_pkg::mem_idx_t      load_idx,
    input  fetch_pkg::word_t         load_data,
    // decoded stream out
    input  logic                     out_ready,
    output logic                     out_valid,
    output fetch_pkg::addr_t         out_pc,
    output fetch_pkg::word_t         out_inst,
    output fetch_pkg::reg_idx_t      out_rd,
    output logic                     out_is_jal
);

    // fetch <-> sram
    logic                rd_en;
    fetch_pkg::mem_idx_t rd_idx;
    fetch_pkg::word_t    rd_data;
    logic                rd_done;

    // fetch <-> decode
    logic                inst_valid;
    logic                inst_ready;
    fetch_pkg::addr_t    inst_pc;
    fetch_pkg::word_t    inst_word;
    logic                jump_en;
    fetch_pkg::addr_t    jump_pc;

    fetch_unit u_fetch_unit (
        .clk        (clk),
        .rst        (rst),
        .inst_ready (inst_ready),
        .jump_en    (jump_en),
        .jump_pc    (jump_pc),
        .rd_data    (rd_data),
        .rd_done    (rd_done),
        .rd_en      (rd_en),
        .rd_idx     (rd_idx),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst_word  (inst_word)
    );

    inst_sram u_inst_sram (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .rd_done (rd_done),
        .wr_en   (load_en),     // loader owns the write side
        .wr_idx  (load_idx),
        .wr_data (load_data)
    );

    decode_unit u_decode_unit (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst_word  (inst_word),
        .inst_ready (inst_ready),
        .jump_en    (jump_en),
        .jump_pc    (jump_pc),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_pc     (out_pc),
        .out_inst   (out_inst),
        .out_rd     (out_rd),
        .out_is_jal (out_is_jal)
    );

endmodule

//--- bench/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // power-on reset over 5 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- bench/fetch_tb.sv
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_items  = 400;
    localparam int idle_limit = 100;   // cycles allowed between accepted items

    logic clk;
    logic por;                         // from the clock module
    logic loading;                     // holds fetch off while the program goes in
    logic rst;

    logic                load_en;
    fetch_pkg::mem_idx_t load_idx;
    fetch_pkg::word_t    load_data;
    logic                out_ready;
    logic                out_valid;
    fetch_pkg::addr_t    out_pc;
    fetch_pkg::word_t    out_inst;
    fetch_pkg::reg_idx_t out_rd;
    logic                out_is_jal;

    fetch_pkg::word_t model_mem [fetch_pkg::mem_depth];   // copy of the loaded program
    fetch_pkg::addr_t model_pc = fetch_pkg::reset_pc;

    int errors = 0;
    int checks = 0;
    int n_acc = 0;                     // accepted items so far
    int n_jal = 0;
    int n_back = 0;                    // backward jumps taken
    int n_wrap = 0;                    // forward jumps that wrapped the index
    int cycle = 0;
    int since_rst = 0;
    int last_acc = 0;
    int prev_acc = 0;
    int ready_since = 0;               // first edge of the current out_ready high run
    logic timed_out = 1'b0;

    // last accepted item as seen on the dut stream
    logic                after_jal = 1'b0;
    fetch_pkg::mem_idx_t jal_idx;
    logic                jal_back;

    // stalled entry seen on the previous edge
    logic                held_valid = 1'b0;
    fetch_pkg::addr_t    held_pc;
    fetch_pkg::word_t    held_inst;
    fetch_pkg::reg_idx_t held_rd;
    logic                held_jal;

    assign rst = por || loading;

    clock_gen u_clock_gen (
        .clk (clk),
        .rst (por)
    );

    fetch_top u_fetch_top (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_idx   (load_idx),
        .load_data  (load_data),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_inst   (out_inst),
        .out_rd     (out_rd),
        .out_is_jal (out_is_jal)
    );

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // last word of each 8-word block is a jal
    // blocks with k % 3 == 2 jump back 11 words into the block before, others skip 9 words
    function automatic fetch_pkg::word_t program_word(input int idx);
        int                  off_bytes;
        fetch_pkg::word_t    off;
        logic [11:0]         imm12;
        fetch_pkg::reg_idx_t rd;
        fetch_pkg::reg_idx_t rs1;
        rd    = fetch_pkg::reg_idx_t'(idx * 5 + 1);
        rs1   = fetch_pkg::reg_idx_t'(idx / 8);
        imm12 = 12'(idx * 29);         // odd multiplier, unique per index
        if (idx % 8 == 7) begin
            off_bytes = ((idx / 8) % 3 == 2) ? -44 : 36;
            off       = fetch_pkg::word_t'(off_bytes);
            return {off[20], off[10:1], off[11], off[19:12], rd, fetch_pkg::opcode_jal};
        end
        return {imm12, rs1, 3'(idx), rd, 7'b0010011};   // op-imm style
    endfunction

    // expected item at pc and the pc after it
    function automatic void reference_item(
        input  fetch_pkg::addr_t    pc,
        output fetch_pkg::word_t    inst,
        output fetch_pkg::reg_idx_t rd,
        output logic                is_jal,
        output fetch_pkg::addr_t    next_pc
    );
        logic [20:0] imm;
        inst   = model_mem[pc[9:2]];
        rd     = inst[11:7];
        is_jal = (inst[6:0] == fetch_pkg::opcode_jal);
        imm    = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        if (is_jal) begin
            next_pc = pc + {{11{imm[20]}}, imm};
        end else begin
            next_pc = pc + 32'd4;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %h expected %h at cycle %0d", name, got, exp, cycle);
        end
    endtask

    // compare on the rising edge, before the DUT registers update
    always @(posedge clk) begin : compare_outputs
        fetch_pkg::word_t    e_inst;
        fetch_pkg::reg_idx_t e_rd;
        logic                e_jal;
        fetch_pkg::addr_t    e_next;
        cycle++;
        if (rst) begin
            since_rst  = 0;
            held_valid = 1'b0;
            if (cycle > 1) begin
                check_value("out_valid", 32'(out_valid), 32'd0);   // cleared by reset
            end
        end else begin
            since_rst++;
            if (!out_ready) begin
                ready_since = cycle + 1;
            end
            if (since_rst <= 3) begin
                check_value("out_valid", 32'(out_valid), 32'd0);   // fetch still running
            end
            if (held_valid) begin
                // entry must sit still under back-pressure
                check_value("out_valid", 32'(out_valid), 32'd1);
                check_value("out_pc", out_pc, held_pc);
                check_value("out_inst", out_inst, held_inst);
                check_value("out_rd", 32'(out_rd), 32'(held_rd));
                check_value("out_is_jal", 32'(out_is_jal), 32'(held_jal));
            end
            if (out_valid && out_ready) begin
                reference_item(model_pc, e_inst, e_rd, e_jal, e_next);
                if (n_acc >= 2 && ready_since <= prev_acc) begin
                    check_value("accept spacing", 32'(cycle - last_acc), 32'd3);
                end
                check_value("out_pc", out_pc, model_pc);
                check_value("out_inst", out_inst, e_inst);
                check_value("out_rd", 32'(out_rd), 32'(e_rd));
                check_value("out_is_jal", 32'(out_is_jal), 32'(e_jal));
                // jump cases taken by the dut stream
                if (after_jal && out_pc[9:2] < jal_idx) begin
                    if (jal_back) begin
                        n_back++;
                    end else begin
                        n_wrap++;              // forward jump past the top
                    end
                end
                if (out_is_jal) begin
                    n_jal++;
                end
                after_jal = out_is_jal;
                jal_idx   = out_pc[9:2];
                jal_back  = out_inst[31];
                model_pc = e_next;
                prev_acc = last_acc;
                last_acc = cycle;
                n_acc++;
            end
            held_valid = out_valid && !out_ready;
            held_pc    = out_pc;
            held_inst  = out_inst;
            held_rd    = out_rd;
            held_jal   = out_is_jal;
        end
    end

    // inputs change on the falling edge only
    initial begin : drive_inputs
        logic [31:0] lfsr;
        int          idle;
        int          last_count;
        loading    = 1'b1;
        load_en    = 1'b0;
        load_idx   = '0;
        load_data  = '0;
        out_ready  = 1'b0;
        lfsr       = 32'd88046;
        idle       = 0;
        last_count = 0;
        for (int idx = 0; idx < fetch_pkg::mem_depth; idx++) begin
            @(negedge clk);
            load_en        = 1'b1;
            load_idx       = fetch_pkg::mem_idx_t'(idx);
            load_data      = program_word(idx);
            model_mem[idx] = load_data;
        end
        @(negedge clk);
        load_en = 1'b0;
        loading = 1'b0;                // fetch starts from here
        while (n_acc < num_items && !timed_out) begin
            @(negedge clk);
            if (n_acc >= 150 && n_acc < 200) begin
                out_ready = 1'b1;      // steady stream window
            end else begin
                lfsr      = lfsr_step(lfsr);
                out_ready = lfsr[0];
            end
            if (n_acc != last_count) begin
                last_count = n_acc;
                idle       = 0;
            end else begin
                idle++;
            end
            if (idle > idle_limit) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: no item was accepted within %0d cycles", idle_limit);
            end
        end
        if (!timed_out && (n_jal == 0 || n_back == 0 || n_wrap == 0)) begin
            errors++;
            $display("program path missed a jump case: jal %0d backward %0d wrap %0d",
                     n_jal, n_back, n_wrap);
        end
        $display("items %0d checks %0d errors %0d", n_acc, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
common/fetch_pkg.sv
fetch/fetch_unit.sv
fetch/inst_sram.sv
src/decode_unit.sv
src/fetch_top.sv
bench/clock_gen.sv
bench/fetch_tb.sv

//--- Makefile
TOP = fetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f filelist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
